//--- run_sim.sh
#!/bin/sh
# build and run the MMU testbench with Verilator, then judge the log
rm -f sim.log
verilator --binary --timing -f src.f --top-module mmu_tb -o mmu_sim \
    && ./obj_dir/mmu_sim > sim.log 2>&1 \
    || echo "build or simulation stopped with an error" >> sim.log
cat sim.log
grep -q "Done: errors found" sim.log && exit 1 \
    || grep -q "Done: no errors" sim.log

//--- src.f
verilog/mmu_cp0_pkg.sv
verilog/mmu_addr_pkg.sv
verilog/cp0_mmu_regs.sv
verilog/tlb_array.sv
verilog/tlb_lookup.sv
verilog/page_resolve.sv
verilog/tlb_data_stage.sv
verilog/mmu_top.sv
tb/tb_clock.sv
tb/mmu_tb.sv

//--- tb/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam mmu_cp0_pkg::tlb_cmd_t CMD_TLBP = 4'b1000;
    localparam mmu_cp0_pkg::tlb_cmd_t CMD_TLBR = 4'b0100;
    localparam mmu_cp0_pkg::tlb_cmd_t CMD_TLBWI = 4'b0010;
    localparam mmu_cp0_pkg::tlb_cmd_t CMD_TLBWR = 4'b0001;

    logic                    clk;
    logic                    rst;
    mmu_addr_pkg::vaddr_u    inst_vaddr;
    logic                    inst_en;
    mmu_addr_pkg::data_req_t data_req;
    logic                    stall;
    logic                    flush;
    mmu_cp0_pkg::tlb_cmd_t   tlb_cmd;
    logic                    mtc0_en;
    mmu_cp0_pkg::cp0_reg_e   mtc0_sel;
    logic [31:0]             mtc0_data;
    mmu_cp0_pkg::cp0_reg_e   mfc0_sel;
    mmu_addr_pkg::xlate_t    inst_xlate;
    mmu_addr_pkg::tlb_exc_t  inst_exc;
    mmu_addr_pkg::xlate_t    data_xlate;
    mmu_addr_pkg::tlb_exc_t  data_exc;
    logic [31:0]             mfc0_data;

    int unsigned cycles = 0;
    // cycle count of the edge that ends reset
    int unsigned rel_cycle;
    logic [31:0] rd_val;
    logic [31:0] last_random;
    logic [7:0]  asid;
    // entry 14 even page, shared by fetch and data tests
    logic [18:0] rw_vpn2;
    logic [19:0] rw_pfn;

    tb_clock tb_clock_inst (.clk(clk));

    mmu_top mmu_top_inst (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_xlate(input string name, input mmu_addr_pkg::xlate_t got,
                               input mmu_addr_pkg::xlate_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_exc(input string name, input mmu_addr_pkg::tlb_exc_t got,
                             input mmu_addr_pkg::tlb_exc_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] mfc0_data (%s): got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] hi_word(input logic [18:0] vpn2, input logic [7:0] id);
        return {vpn2, 5'b0, id};
    endfunction

    function automatic logic [31:0] lo_word(input logic [19:0] pfn, input logic [2:0] c,
                                            input logic d, input logic v, input logic g);
        return {6'b0, pfn, c, d, v, g};
    endfunction

    // tag in the top four bits keeps the test pages apart
    function automatic logic [18:0] rand_vpn2(input logic [3:0] tag);
        return {tag, 15'($urandom)};
    endfunction

    task automatic write_cp0(input mmu_cp0_pkg::cp0_reg_e sel, input logic [31:0] data);
        @(posedge clk);
        mtc0_en <= 1'b1;
        mtc0_sel <= sel;
        mtc0_data <= data;
        @(posedge clk);
        mtc0_en <= 1'b0;
    endtask

    task automatic read_cp0(input mmu_cp0_pkg::cp0_reg_e sel);
        @(posedge clk);
        mfc0_sel <= sel;
        @(negedge clk);
        rd_val = mfc0_data;
    endtask

    // Random is sampled in the pulse cycle, the value a TLBWR writes at
    task automatic run_cmd(input mmu_cp0_pkg::tlb_cmd_t cmd);
        @(posedge clk);
        tlb_cmd <= cmd;
        mfc0_sel <= mmu_cp0_pkg::RANDOM;
        @(negedge clk);
        // counts down from 31 since the edge that ended reset
        last_random = 32'(31 - (cycles - rel_cycle) % 32);
        check_word("Random", mfc0_data, last_random);
        @(posedge clk);
        tlb_cmd <= '0;
    endtask

    task automatic write_entry(input int idx, input logic [31:0] hi, input logic [31:0] lo0,
                               input logic [31:0] lo1);
        write_cp0(mmu_cp0_pkg::INDEX, 32'(idx));
        write_cp0(mmu_cp0_pkg::ENTRY_HI, hi);
        write_cp0(mmu_cp0_pkg::ENTRY_LO0, lo0);
        write_cp0(mmu_cp0_pkg::ENTRY_LO1, lo1);
        run_cmd(CMD_TLBWI);
    endtask

    task automatic probe_index(input logic [31:0] hi, input logic [31:0] exp);
        write_cp0(mmu_cp0_pkg::ENTRY_HI, hi);
        run_cmd(CMD_TLBP);
        read_cp0(mmu_cp0_pkg::INDEX);
        check_word("Index", rd_val, exp);
    endtask

    // fetch is combinational, data lands in M at the second edge
    task automatic present(input logic [31:0] ia, input logic en, input logic [31:0] da,
                           input logic rd, input logic wr);
        @(posedge clk);
        inst_vaddr <= ia;
        inst_en <= en;
        data_req <= {da, rd, wr};
        @(posedge clk);
        data_req <= '0;
        @(negedge clk);
    endtask

    task automatic test_unmapped();
        logic [31:0] a;
        for (int i = 0; i < 8; i++) begin
            a = {2'b10, i[0], 29'($urandom)};
            present(a, 1'b1, a, 1'b1, 1'b0);
            check_xlate("inst_xlate", inst_xlate, {3'b000, a[28:12], a[29]});
            check_exc("inst_exc", inst_exc, 3'b000);
            check_xlate("data_xlate", data_xlate, {3'b000, a[28:12], a[29]});
            check_exc("data_exc", data_exc, 3'b000);
        end
    endtask

    task automatic test_write_read();
        logic [18:0] vpn2;
        logic [19:0] pfn0;
        logic [19:0] pfn1;
        logic [15:0] mask;
        // low bits set so the mask has something to clear
        vpn2 = rand_vpn2(4'd1) | 19'h3;
        pfn0 = 20'($urandom) | 20'h3;
        pfn1 = 20'($urandom) | 20'h3;
        mask = 16'h0003;
        write_cp0(mmu_cp0_pkg::PAGE_MASK, {3'b0, mask, 13'b0});
        write_entry(5, hi_word(vpn2, asid), lo_word(pfn0, 3'd3, 1'b1, 1'b1, 1'b1),
                    lo_word(pfn1, 3'd2, 1'b0, 1'b1, 1'b0));
        // wipe the registers so only TLBR can restore them
        write_cp0(mmu_cp0_pkg::ENTRY_HI, 32'h0);
        write_cp0(mmu_cp0_pkg::ENTRY_LO0, 32'h0);
        write_cp0(mmu_cp0_pkg::ENTRY_LO1, 32'h0);
        write_cp0(mmu_cp0_pkg::PAGE_MASK, 32'h0);
        run_cmd(CMD_TLBR);
        read_cp0(mmu_cp0_pkg::ENTRY_HI);
        check_word("EntryHi", rd_val, hi_word(vpn2 & ~{3'b0, mask}, asid));
        read_cp0(mmu_cp0_pkg::PAGE_MASK);
        check_word("PageMask", rd_val, {3'b0, mask, 13'b0});
        read_cp0(mmu_cp0_pkg::ENTRY_LO0);
        check_word("EntryLo0", rd_val,
                   lo_word(pfn0 & ~{4'b0, mask}, 3'd3, 1'b1, 1'b1, 1'b0));
        read_cp0(mmu_cp0_pkg::ENTRY_LO1);
        check_word("EntryLo1", rd_val,
                   lo_word(pfn1 & ~{4'b0, mask}, 3'd2, 1'b0, 1'b1, 1'b0));
        write_cp0(mmu_cp0_pkg::PAGE_MASK, 32'h0);
    endtask

    task automatic test_probe();
        logic [18:0] vpn2;
        logic [18:0] gvpn2;
        vpn2 = rand_vpn2(4'd2);
        gvpn2 = rand_vpn2(4'd3);
        write_entry(9, hi_word(vpn2, asid), lo_word(20'($urandom), 3'd3, 1'b1, 1'b1, 1'b0),
                    lo_word(20'($urandom), 3'd3, 1'b1, 1'b1, 1'b0));
        write_entry(12, hi_word(gvpn2, asid), lo_word(20'($urandom), 3'd3, 1'b1, 1'b1, 1'b1),
                    lo_word(20'($urandom), 3'd3, 1'b1, 1'b1, 1'b1));
        probe_index(hi_word(vpn2, asid), 32'd9);
        probe_index(hi_word(vpn2 ^ 19'd1, asid), 32'h8000_0000);
        probe_index(hi_word(vpn2, asid ^ 8'h5a), 32'h8000_0000);
        // global entry ignores the ASID
        probe_index(hi_word(gvpn2, asid ^ 8'h5a), 32'd12);
    endtask

    task automatic test_fetch();
        logic [18:0] inv_vpn2;
        logic [18:0] miss_vpn2;
        logic [19:0] pfn1;
        rw_vpn2 = rand_vpn2(4'd4);
        inv_vpn2 = rand_vpn2(4'd5);
        miss_vpn2 = rand_vpn2(4'd7);
        rw_pfn = 20'($urandom);
        pfn1 = 20'($urandom);
        write_entry(14, hi_word(rw_vpn2, asid), lo_word(rw_pfn, 3'd3, 1'b1, 1'b1, 1'b0),
                    lo_word(pfn1, 3'd2, 1'b1, 1'b1, 1'b0));
        write_entry(15, hi_word(inv_vpn2, asid), lo_word(pfn1, 3'd3, 1'b1, 1'b0, 1'b0),
                    lo_word(pfn1, 3'd3, 1'b1, 1'b1, 1'b0));
        present({rw_vpn2, 1'b0, 12'h3a4}, 1'b1, 32'h8000_0000, 1'b0, 1'b0);
        check_xlate("inst_xlate", inst_xlate, {rw_pfn, 1'b0});
        check_exc("inst_exc", inst_exc, 3'b000);
        present({rw_vpn2, 1'b1, 12'h05c}, 1'b1, 32'h8000_0000, 1'b0, 1'b0);
        check_xlate("inst_xlate", inst_xlate, {pfn1, 1'b1});
        check_exc("inst_exc", inst_exc, 3'b000);
        present({inv_vpn2, 1'b0, 12'h100}, 1'b1, 32'h8000_0000, 1'b0, 1'b0);
        check_exc("inst_exc", inst_exc, 3'b010);
        present({miss_vpn2, 1'b0, 12'h100}, 1'b1, 32'h8000_0000, 1'b0, 1'b0);
        check_exc("inst_exc", inst_exc, 3'b100);
        present({miss_vpn2, 1'b0, 12'h100}, 1'b0, 32'h8000_0000, 1'b0, 1'b0);
        check_exc("inst_exc", inst_exc, 3'b000);
    endtask

    task automatic test_data();
        logic [18:0] clean_vpn2;
        logic [19:0] clean_pfn;
        clean_vpn2 = rand_vpn2(4'd6);
        clean_pfn = 20'($urandom);
        write_entry(16, hi_word(clean_vpn2, asid), lo_word(clean_pfn, 3'd3, 1'b0, 1'b1, 1'b0),
                    lo_word(clean_pfn, 3'd3, 1'b1, 1'b1, 1'b0));
        // store to the clean page, M still idle in the cycle it is presented
        @(posedge clk);
        data_req <= {clean_vpn2, 1'b0, 12'h010, 2'b01};
        @(negedge clk);
        check_exc("data_exc", data_exc, 3'b000);
        @(posedge clk);
        data_req <= '0;
        @(negedge clk);
        check_exc("data_exc", data_exc, 3'b001);
        check_xlate("data_xlate", data_xlate, {clean_pfn, 1'b0});
        present(32'h8000_0000, 1'b0, {rw_vpn2, 1'b0, 12'h020}, 1'b0, 1'b1);
        check_exc("data_exc", data_exc, 3'b000);
        present(32'h8000_0000, 1'b0, {rand_vpn2(4'd7), 1'b0, 12'h0}, 1'b1, 1'b0);
        check_exc("data_exc", data_exc, 3'b100);
        // read in M, then a store arrives while stalled
        @(posedge clk);
        data_req <= {rw_vpn2, 1'b0, 12'h040, 2'b10};
        @(posedge clk);
        stall <= 1'b1;
        data_req <= {clean_vpn2, 1'b0, 12'h010, 2'b01};
        @(posedge clk);
        @(negedge clk);
        check_xlate("data_xlate", data_xlate, {rw_pfn, 1'b0});
        check_exc("data_exc", data_exc, 3'b000);
        @(posedge clk);
        stall <= 1'b0;
        @(posedge clk);
        flush <= 1'b1;
        @(negedge clk);
        check_exc("data_exc", data_exc, 3'b001);
        @(posedge clk);
        flush <= 1'b0;
        data_req <= '0;
        @(negedge clk);
        check_exc("data_exc", data_exc, 3'b000);
    endtask

    task automatic test_random_write();
        logic [18:0] vpn2;
        logic [19:0] pfn0;
        logic [19:0] pfn1;
        logic [31:0] wr_idx;
        vpn2 = rand_vpn2(4'd12);
        pfn0 = 20'($urandom);
        pfn1 = 20'($urandom);
        write_cp0(mmu_cp0_pkg::ENTRY_HI, hi_word(vpn2, asid));
        write_cp0(mmu_cp0_pkg::ENTRY_LO0, lo_word(pfn0, 3'd3, 1'b1, 1'b1, 1'b1));
        write_cp0(mmu_cp0_pkg::ENTRY_LO1, lo_word(pfn1, 3'd3, 1'b0, 1'b1, 1'b1));
        run_cmd(CMD_TLBWR);
        wr_idx = last_random;
        run_cmd(CMD_TLBP);
        read_cp0(mmu_cp0_pkg::INDEX);
        check_word("Index", rd_val, wr_idx);
        write_cp0(mmu_cp0_pkg::ENTRY_HI, 32'h0);
        write_cp0(mmu_cp0_pkg::ENTRY_LO0, 32'h0);
        write_cp0(mmu_cp0_pkg::ENTRY_LO1, 32'h0);
        run_cmd(CMD_TLBR);
        read_cp0(mmu_cp0_pkg::ENTRY_HI);
        check_word("EntryHi", rd_val, hi_word(vpn2, asid));
        read_cp0(mmu_cp0_pkg::ENTRY_LO0);
        check_word("EntryLo0", rd_val, lo_word(pfn0, 3'd3, 1'b1, 1'b1, 1'b1));
        read_cp0(mmu_cp0_pkg::ENTRY_LO1);
        check_word("EntryLo1", rd_val, lo_word(pfn1, 3'd3, 1'b0, 1'b1, 1'b1));
        present({vpn2, 1'b1, 12'h7f0}, 1'b1, 32'h8000_0000, 1'b0, 1'b0);
        check_xlate("inst_xlate", inst_xlate, {pfn1, 1'b0});
        check_exc("inst_exc", inst_exc, 3'b000);
    endtask

    initial begin
        void'($urandom(99792));
        rst <= 1'b1;
        inst_vaddr <= '0;
        inst_en <= 1'b0;
        data_req <= '0;
        stall <= 1'b0;
        flush <= 1'b0;
        tlb_cmd <= '0;
        mtc0_en <= 1'b0;
        mtc0_sel <= mmu_cp0_pkg::ENTRY_HI;
        mtc0_data <= '0;
        mfc0_sel <= mmu_cp0_pkg::ENTRY_HI;
        // nonzero so the cleared entries never match
        asid = 8'($urandom_range(255, 1));
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        rel_cycle = cycles + 1;
        test_unmapped();
        test_write_read();
        test_probe();
        test_fetch();
        test_data();
        test_random_write();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

//--- verilog/cp0_mmu_regs.sv
`timescale 1ns/1ps

module cp0_mmu_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               mtc0_en,
    input  mmu_cp0_pkg::cp0_reg_e              mtc0_sel,
    input  logic [31:0]                        mtc0_data,
    input  mmu_cp0_pkg::cp0_reg_e              mfc0_sel,
    output logic [31:0]                        mfc0_data,
    input  mmu_cp0_pkg::tlb_cmd_t              tlb_cmd,
    input  mmu_addr_pkg::lookup_t              probe,
    input  mmu_cp0_pkg::tlb_entry_t            rd_entry,
    output mmu_cp0_pkg::entry_hi_t             entry_hi,
    output mmu_cp0_pkg::page_mask_t            page_mask,
    output mmu_cp0_pkg::entry_lo_t             entry_lo0,
    output mmu_cp0_pkg::entry_lo_t             entry_lo1,
    output logic [mmu_cp0_pkg::TLB_IDX_W-1:0] index,
    output logic [mmu_cp0_pkg::TLB_IDX_W-1:0] random
);

    // probe failure flag, bit 31 of Index
    logic index_p;

    // register images rebuilt from the stored entry for TLBR
    mmu_cp0_pkg::entry_hi_t  rd_hi;
    mmu_cp0_pkg::page_mask_t rd_mask;
    mmu_cp0_pkg::entry_lo_t  rd_lo0;
    mmu_cp0_pkg::entry_lo_t  rd_lo1;

    // global bit goes back into both halves
    assign rd_hi = {rd_entry.vpn2, 5'b0, rd_entry.asid};
    assign rd_mask = {3'b0, rd_entry.mask, 13'b0};
    assign rd_lo0 = {6'b0, rd_entry.lo0.pfn, rd_entry.lo0.c, rd_entry.lo0.d,
                     rd_entry.lo0.v, rd_entry.g};
    assign rd_lo1 = {6'b0, rd_entry.lo1.pfn, rd_entry.lo1.c, rd_entry.lo1.d,
                     rd_entry.lo1.v, rd_entry.g};

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_hi <= '0;
            page_mask <= '0;
            entry_lo0 <= '0;
            entry_lo1 <= '0;
            index <= '0;
            index_p <= 1'b0;
        end else if (tlb_cmd.tlbr) begin
            entry_hi <= rd_hi;
            page_mask <= rd_mask;
            entry_lo0 <= rd_lo0;
            entry_lo1 <= rd_lo1;
        end else if (tlb_cmd.tlbp) begin
            // miss leaves only the P bit set
            index_p <= ~probe.hit;
            index <= probe.hit ? probe.idx : '0;
        end else if (mtc0_en) begin
            case (mtc0_sel)
                mmu_cp0_pkg::ENTRY_HI:  entry_hi <= {mtc0_data[31:13], 5'b0, mtc0_data[7:0]};
                mmu_cp0_pkg::PAGE_MASK: page_mask <= {3'b0, mtc0_data[28:13], 13'b0};
                mmu_cp0_pkg::ENTRY_LO0: entry_lo0 <= {6'b0, mtc0_data[25:0]};
                mmu_cp0_pkg::ENTRY_LO1: entry_lo1 <= {6'b0, mtc0_data[25:0]};
                mmu_cp0_pkg::INDEX: begin
                    index <= mtc0_data[mmu_cp0_pkg::TLB_IDX_W-1:0];
                    index_p <= 1'b0;
                end
                // random is read only
                default: ;
            endcase
        end
    end

    // free-running, wraps 0 -> 31
    always_ff @(posedge clk) begin
        if (rst) begin
            random <= '1;
        end else begin
            random <= random - 1'b1;
        end
    end

    always_comb begin
        mfc0_data = '0;
        case (mfc0_sel)
            mmu_cp0_pkg::ENTRY_HI:  mfc0_data = entry_hi;
            mmu_cp0_pkg::PAGE_MASK: mfc0_data = page_mask;
            mmu_cp0_pkg::ENTRY_LO0: mfc0_data = entry_lo0;
            mmu_cp0_pkg::ENTRY_LO1: mfc0_data = entry_lo1;
            mmu_cp0_pkg::INDEX: begin
                mfc0_data = 32'(index);
                mfc0_data[31] = index_p;
            end
            mmu_cp0_pkg::RANDOM:    mfc0_data = 32'(random);
            default:                mfc0_data = '0;
        endcase
    end

endmodule

//--- verilog/mmu_addr_pkg.sv
package mmu_addr_pkg;

    // upper bits 2'b10 select kseg0/kseg1
    localparam logic [1:0] KSEG01_TOP = 2'd2;
    localparam logic [2:0] KSEG1_SEG = 3'd5;

    // one virtual address, seen as mapped page or as segment
    typedef union packed {
        struct packed {
            logic [18:0] vpn2;
            logic        odd;
            logic [11:0] offset;
        } mapped;
        struct packed {
            logic [2:0]  seg;
            logic [28:0] seg_off;
        } seg;
    } vaddr_u;

    typedef struct packed {
        vaddr_u vaddr;
        logic   read;
        logic   write;
    } data_req_t;

    typedef struct packed {
        logic [19:0] pfn;
        logic        uncached;
    } xlate_t;

    typedef struct packed {
        logic refill;
        logic invalid;
        logic modify;
    } tlb_exc_t;

    typedef struct packed {
        logic                               hit;
        logic [mmu_cp0_pkg::TLB_IDX_W-1:0] idx;
    } lookup_t;

endpackage

//--- verilog/mmu_cp0_pkg.sv
package mmu_cp0_pkg;

    // joint TLB geometry
    localparam int TLB_ENTRIES = 32;
    localparam int TLB_IDX_W = 5;

    // cache attribute meaning uncached
    localparam logic [2:0] UNCACHED_C = 3'd2;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [4:0]  zero;
        logic [7:0]  asid;
    } entry_hi_t;

    typedef struct packed {
        logic [5:0]  zero;
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
        logic        g;
    } entry_lo_t;

    // mask bits cover address bits 28:13
    typedef struct packed {
        logic [2:0]  zero_hi;
        logic [15:0] mask;
        logic [12:0] zero_lo;
    } page_mask_t;

    // one page of the even/odd pair
    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
    } tlb_half_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [15:0] mask;
        tlb_half_t   lo0;
        tlb_half_t   lo1;
    } tlb_entry_t;

    typedef struct packed {
        logic tlbp;
        logic tlbr;
        logic tlbwi;
        logic tlbwr;
    } tlb_cmd_t;

    typedef enum logic [2:0] {
        ENTRY_HI,
        PAGE_MASK,
        ENTRY_LO0,
        ENTRY_LO1,
        INDEX,
        RANDOM
    } cp0_reg_e;

endpackage

//--- verilog/mmu_top.sv
`timescale 1ns/1ps

module mmu_top (
    input  logic                    clk,
    input  logic                    rst,
    input  mmu_addr_pkg::vaddr_u    inst_vaddr,
    input  logic                    inst_en,
    input  mmu_addr_pkg::data_req_t data_req,
    input  logic                    stall,
    input  logic                    flush,
    input  mmu_cp0_pkg::tlb_cmd_t   tlb_cmd,
    input  logic                    mtc0_en,
    input  mmu_cp0_pkg::cp0_reg_e   mtc0_sel,
    input  logic [31:0]             mtc0_data,
    input  mmu_cp0_pkg::cp0_reg_e   mfc0_sel,
    output mmu_addr_pkg::xlate_t    inst_xlate,
    output mmu_addr_pkg::tlb_exc_t  inst_exc,
    output mmu_addr_pkg::xlate_t    data_xlate,
    output mmu_addr_pkg::tlb_exc_t  data_exc,
    output logic [31:0]             mfc0_data
);

    mmu_cp0_pkg::entry_hi_t             entry_hi;
    mmu_cp0_pkg::page_mask_t            page_mask;
    mmu_cp0_pkg::entry_lo_t             entry_lo0;
    mmu_cp0_pkg::entry_lo_t             entry_lo1;
    logic [mmu_cp0_pkg::TLB_IDX_W-1:0] index;
    logic [mmu_cp0_pkg::TLB_IDX_W-1:0] random;

    mmu_cp0_pkg::tlb_entry_t entries [mmu_cp0_pkg::TLB_ENTRIES];
    mmu_cp0_pkg::tlb_entry_t rd_entry_i;
    mmu_cp0_pkg::tlb_entry_t rd_entry_d;

    mmu_addr_pkg::lookup_t   inst_look;
    mmu_addr_pkg::lookup_t   data_look_e;
    mmu_addr_pkg::lookup_t   data_look_m;
    mmu_addr_pkg::data_req_t data_req_m;
    mmu_addr_pkg::vaddr_u    data_look_vaddr;

    // TLBP borrows the data lookup port with EntryHi
    assign data_look_vaddr = tlb_cmd.tlbp ? mmu_addr_pkg::vaddr_u'(entry_hi) : data_req.vaddr;

    cp0_mmu_regs cp0_mmu_regs_inst (
        .clk       (clk),
        .rst       (rst),
        .mtc0_en   (mtc0_en),
        .mtc0_sel  (mtc0_sel),
        .mtc0_data (mtc0_data),
        .mfc0_sel  (mfc0_sel),
        .mfc0_data (mfc0_data),
        .tlb_cmd   (tlb_cmd),
        .probe     (data_look_e),
        .rd_entry  (rd_entry_d),
        .entry_hi  (entry_hi),
        .page_mask (page_mask),
        .entry_lo0 (entry_lo0),
        .entry_lo1 (entry_lo1),
        .index     (index),
        .random    (random)
    );

    tlb_array tlb_array_inst (
        .clk        (clk),
        .rst        (rst),
        .tlb_cmd    (tlb_cmd),
        .entry_hi   (entry_hi),
        .page_mask  (page_mask),
        .entry_lo0  (entry_lo0),
        .entry_lo1  (entry_lo1),
        .index      (index),
        .random     (random),
        .entries    (entries),
        .rd_idx_i   (inst_look.idx),
        .rd_entry_i (rd_entry_i),
        .m_idx      (data_look_m.idx),
        .rd_entry_d (rd_entry_d)
    );

    tlb_lookup inst_lookup_inst (
        .vaddr   (inst_vaddr),
        .asid    (entry_hi.asid),
        .entries (entries),
        .result  (inst_look)
    );

    tlb_lookup data_lookup_inst (
        .vaddr   (data_look_vaddr),
        .asid    (entry_hi.asid),
        .entries (entries),
        .result  (data_look_e)
    );

    tlb_data_stage tlb_data_stage_inst (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .flush  (flush),
        .req_e  (data_req),
        .look_e (data_look_e),
        .req_m  (data_req_m),
        .look_m (data_look_m)
    );

    // fetch never writes, so modify stays low here
    page_resolve inst_resolve_inst (
        .vaddr (inst_vaddr),
        .read  (inst_en),
        .write (1'b0),
        .look  (inst_look),
        .entry (rd_entry_i),
        .xlate (inst_xlate),
        .exc   (inst_exc)
    );

    page_resolve data_resolve_inst (
        .vaddr (data_req_m.vaddr),
        .read  (data_req_m.read),
        .write (data_req_m.write),
        .look  (data_look_m),
        .entry (rd_entry_d),
        .xlate (data_xlate),
        .exc   (data_exc)
    );

endmodule

//--- verilog/page_resolve.sv
`timescale 1ns/1ps

module page_resolve (
    input  mmu_addr_pkg::vaddr_u    vaddr,
    input  logic                    read,
    input  logic                    write,
    input  mmu_addr_pkg::lookup_t   look,
    input  mmu_cp0_pkg::tlb_entry_t entry,
    output mmu_addr_pkg::xlate_t    xlate,
    output mmu_addr_pkg::tlb_exc_t  exc
);

    logic                   unmapped;
    logic                   kseg1;
    logic                   access;
    mmu_cp0_pkg::tlb_half_t half;

    assign unmapped = vaddr.seg.seg[2:1] == mmu_addr_pkg::KSEG01_TOP;
    assign kseg1 = vaddr.seg.seg == mmu_addr_pkg::KSEG1_SEG;
    assign access = read | write;

    // bit 12 picks the even or odd page
    assign half = vaddr.mapped.odd ? entry.lo1 : entry.lo0;

    always_comb begin
        if (unmapped) begin
            // fixed window onto the low 512 MB
            xlate.pfn = {3'b000, vaddr.seg.seg_off[28:12]};
            xlate.uncached = kseg1;
        end else begin
            xlate.pfn = half.pfn;
            xlate.uncached = half.c == mmu_cp0_pkg::UNCACHED_C;
        end
    end

    always_comb begin
        exc = '0;
        if (!unmapped) begin
            exc.refill = access & ~look.hit;
            exc.invalid = access & look.hit & ~half.v;
            // store to a clean valid page
            exc.modify = write & look.hit & half.v & ~half.d;
        end
    end

endmodule

//--- verilog/tlb_array.sv
`timescale 1ns/1ps

module tlb_array (
    input  logic                               clk,
    input  logic                               rst,
    input  mmu_cp0_pkg::tlb_cmd_t              tlb_cmd,
    input  mmu_cp0_pkg::entry_hi_t             entry_hi,
    input  mmu_cp0_pkg::page_mask_t            page_mask,
    input  mmu_cp0_pkg::entry_lo_t             entry_lo0,
    input  mmu_cp0_pkg::entry_lo_t             entry_lo1,
    input  logic [mmu_cp0_pkg::TLB_IDX_W-1:0] index,
    input  logic [mmu_cp0_pkg::TLB_IDX_W-1:0] random,
    output mmu_cp0_pkg::tlb_entry_t            entries [mmu_cp0_pkg::TLB_ENTRIES],
    input  logic [mmu_cp0_pkg::TLB_IDX_W-1:0] rd_idx_i,
    output mmu_cp0_pkg::tlb_entry_t            rd_entry_i,
    input  logic [mmu_cp0_pkg::TLB_IDX_W-1:0] m_idx,
    output mmu_cp0_pkg::tlb_entry_t            rd_entry_d
);

    mmu_cp0_pkg::tlb_entry_t            mem [mmu_cp0_pkg::TLB_ENTRIES];
    mmu_cp0_pkg::tlb_entry_t            wr_entry;
    logic [mmu_cp0_pkg::TLB_IDX_W-1:0] wr_idx;
    logic [mmu_cp0_pkg::TLB_IDX_W-1:0] rd_idx_d;

    assign wr_idx = tlb_cmd.tlbwi ? index : random;
    assign rd_idx_d = tlb_cmd.tlbr ? index : m_idx;

    // bits covered by the mask are dropped before storing
    always_comb begin
        wr_entry.vpn2 = entry_hi.vpn2 & ~{3'b000, page_mask.mask};
        wr_entry.asid = entry_hi.asid;
        wr_entry.g = entry_lo0.g & entry_lo1.g;
        wr_entry.mask = page_mask.mask;
        wr_entry.lo0 = {entry_lo0.pfn & ~{4'b0000, page_mask.mask},
                        entry_lo0.c, entry_lo0.d, entry_lo0.v};
        wr_entry.lo1 = {entry_lo1.pfn & ~{4'b0000, page_mask.mask},
                        entry_lo1.c, entry_lo1.d, entry_lo1.v};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mmu_cp0_pkg::TLB_ENTRIES; i++) begin
                mem[i] <= '0;
            end
        end else if (tlb_cmd.tlbwi || tlb_cmd.tlbwr) begin
            mem[wr_idx] <= wr_entry;
        end
    end

    assign entries = mem;
    assign rd_entry_i = mem[rd_idx_i];
    // TLBR takes the data port read
    assign rd_entry_d = mem[rd_idx_d];

endmodule

//--- verilog/tlb_data_stage.sv
`timescale 1ns/1ps

module tlb_data_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    flush,
    input  mmu_addr_pkg::data_req_t req_e,
    input  mmu_addr_pkg::lookup_t   look_e,
    output mmu_addr_pkg::data_req_t req_m,
    output mmu_addr_pkg::lookup_t   look_m
);

    // E -> M register for the data port
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // clearing read/write silences the M-stage exceptions
            req_m <= '0;
            look_m <= '0;
        end else if (!stall) begin
            req_m <= req_e;
            look_m <= look_e;
        end
    end

endmodule

//--- verilog/tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup (
    input  mmu_addr_pkg::vaddr_u    vaddr,
    input  logic [7:0]              asid,
    input  mmu_cp0_pkg::tlb_entry_t entries [mmu_cp0_pkg::TLB_ENTRIES],
    output mmu_addr_pkg::lookup_t   result
);

    logic [mmu_cp0_pkg::TLB_ENTRIES-1:0] match;
    logic [mmu_cp0_pkg::TLB_IDX_W-1:0]   idx;

    // per-entry compare of vpn2 under the entry mask
    always_comb begin
        logic [18:0] keep;
        keep = '0;
        for (int i = 0; i < mmu_cp0_pkg::TLB_ENTRIES; i++) begin
            keep = ~{3'b000, entries[i].mask};
            match[i] = ((vaddr.mapped.vpn2 & keep) == (entries[i].vpn2 & keep))
                       && (entries[i].g || (entries[i].asid == asid));
        end
    end

    // one-hot match, so OR of the matching indices
    always_comb begin
        idx = '0;
        for (int i = 0; i < mmu_cp0_pkg::TLB_ENTRIES; i++) begin
            idx = idx | ({mmu_cp0_pkg::TLB_IDX_W{match[i]}}
                         & i[mmu_cp0_pkg::TLB_IDX_W-1:0]);
        end
    end

    assign result.hit = |match;
    assign result.idx = idx;

endmodule
